/* include/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// lanes per cycle, in and out
`define N_WAY 3
`define XLEN 32

// physical register space
`define N_PHY_REG 64
`define TAG_BITS 6
`define ZERO_REG 0

// per-cycle issue limits by unit kind
`define EX_ALU_UNITS 2
`define EX_MULT_UNITS 1
`define EX_LOAD_UNITS 1
`define EX_STORE_UNITS 1
`define EX_BRANCH_UNITS 1

`endif

/* hw/rv32_isa_pkg.sv */
package rv32_isa_pkg;

	// major opcodes handled by the decoder
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_IMM    = 7'b0010011,
		OPC_REG    = 7'b0110011
	} opcode_e;

	// R-type field layout, other formats reuse the same bit positions
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e opcode;
	} inst_word_t;

	// funct3 for integer ops
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct7 variants
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

/* hw/issue_pkg.sv */
`include "issue_params.svh"

package issue_pkg;

	typedef enum logic [2:0] {ALU, MULT, LOAD, STORE, BRANCH} exec_unit_e;

	typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_RS2, OPB_I_IMM, OPB_S_IMM, OPB_B_IMM, OPB_U_IMM, OPB_J_IMM
	} opb_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
	} alu_func_e;

	////////////////////////////////////////////////////
	// stage traffic
	////////////////////////////////////////////////////

	// renamed instruction from the reservation station
	typedef struct packed {
		logic valid;
		rv32_isa_pkg::inst_word_t inst;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] npc;
		logic [`TAG_BITS-1:0] src_tag_1;
		logic [`TAG_BITS-1:0] src_tag_2;
		logic [`TAG_BITS-1:0] dest_tag;
	} rs_lane_t;

	typedef struct packed {
		logic en;
		logic [`TAG_BITS-1:0] idx;
		logic [`XLEN-1:0] data;
	} wb_port_t;

	typedef struct packed {
		opa_sel_e opa_sel;
		opb_sel_e opb_sel;
		alu_func_e alu_func;
		logic rd_mem;
		logic wr_mem;
		logic cond_branch;
		logic uncond_branch;
		logic illegal;
		exec_unit_e unit;
		logic [`TAG_BITS-1:0] dest_idx;
	} decoded_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] npc;
		rv32_isa_pkg::inst_word_t inst;
		logic [`XLEN-1:0] rs1_value;
		logic [`XLEN-1:0] rs2_value;
		opa_sel_e opa_sel;
		opb_sel_e opb_sel;
		alu_func_e alu_func;
		logic rd_mem;
		logic wr_mem;
		logic cond_branch;
		logic uncond_branch;
		logic illegal;
		exec_unit_e unit;
		logic [`TAG_BITS-1:0] dest_idx;
	} issue_packet_t;

endpackage

/* hw/issue_regfile.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_regfile (
	input  logic clock,
	input  issue_pkg::wb_port_t [`N_WAY-1:0] wb,
	input  logic [`N_WAY-1:0][`TAG_BITS-1:0] rd_tags_1,
	input  logic [`N_WAY-1:0][`TAG_BITS-1:0] rd_tags_2,
	output logic [`N_WAY-1:0][`XLEN-1:0] rs1_values,
	output logic [`N_WAY-1:0][`XLEN-1:0] rs2_values
);

	logic [`XLEN-1:0] regs [`N_PHY_REG];

	// later ports overwrite earlier ones on the same index
	always_ff @(posedge clock) begin
		for (int w = 0; w < `N_WAY; w++) begin
			if (wb[w].en && (wb[w].idx != '0)) begin
				regs[wb[w].idx] <= wb[w].data;
			end
		end
	end

	// no bypass, a write shows up on the next cycle
	always_comb begin
		for (int k = 0; k < `N_WAY; k++) begin
			if (rd_tags_1[k] == '0) begin
				rs1_values[k] = '0;
			end else begin
				rs1_values[k] = regs[rd_tags_1[k]];
			end
			if (rd_tags_2[k] == '0) begin
				rs2_values[k] = '0;
			end else begin
				rs2_values[k] = regs[rd_tags_2[k]];
			end
		end
	end

endmodule

/* hw/inst_decoder.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module inst_decoder (
	input  issue_pkg::rs_lane_t lane,
	output issue_pkg::decoded_t decoded
);
	import rv32_isa_pkg::*;
	import issue_pkg::*;

	inst_word_t inst;

	// integer op from funct3, alt picks SUB or SRA
	function automatic alu_func_e int_func(input logic [2:0] f3, input logic alt);
		alu_func_e f;
		case (f3)
			F3_ADD: f = alt ? ALU_SUB : ALU_ADD;
			F3_SLL: f = ALU_SLL;
			F3_SLT: f = ALU_SLT;
			F3_SLTU: f = ALU_SLTU;
			F3_XOR: f = ALU_XOR;
			F3_SR: f = alt ? ALU_SRA : ALU_SRL;
			F3_OR: f = ALU_OR;
			default: f = ALU_AND;
		endcase
		return f;
	endfunction

	assign inst = lane.inst;

	always_comb begin : decode_lane
		logic writes_rd;
		// defaults are an add of rs1 and rs2 with no destination
		decoded = '0;
		decoded.opa_sel = OPA_RS1;
		decoded.opb_sel = OPB_RS2;
		decoded.alu_func = ALU_ADD;
		decoded.unit = ALU;
		writes_rd = 1'b0;
		if (lane.valid) begin
			case (inst.opcode)
				OPC_LUI: begin
					decoded.opa_sel = OPA_ZERO;
					decoded.opb_sel = OPB_U_IMM;
					writes_rd = 1'b1;
				end
				OPC_AUIPC: begin
					decoded.opa_sel = OPA_PC;
					decoded.opb_sel = OPB_U_IMM;
					writes_rd = 1'b1;
				end
				OPC_JAL: begin
					decoded.opa_sel = OPA_PC;
					decoded.opb_sel = OPB_J_IMM;
					decoded.uncond_branch = 1'b1;
					writes_rd = 1'b1;
				end
				OPC_JALR: begin
					if (inst.funct3 == 3'b000) begin
						decoded.opb_sel = OPB_I_IMM;
						decoded.uncond_branch = 1'b1;
						writes_rd = 1'b1;
					end else begin
						decoded.illegal = 1'b1;
					end
				end
				OPC_BRANCH: begin
					decoded.unit = BRANCH;
					// funct3 010 and 011 are unused
					if (inst.funct3[2:1] != 2'b01) begin
						decoded.opa_sel = OPA_PC;
						decoded.opb_sel = OPB_B_IMM;
						decoded.cond_branch = 1'b1;
					end else begin
						decoded.illegal = 1'b1;
					end
				end
				OPC_LOAD: begin
					decoded.unit = LOAD;
					if (inst.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
						decoded.opb_sel = OPB_I_IMM;
						decoded.rd_mem = 1'b1;
						writes_rd = 1'b1;
					end else begin
						decoded.illegal = 1'b1;
					end
				end
				OPC_STORE: begin
					decoded.unit = STORE;
					if (inst.funct3 inside {3'b000, 3'b001, 3'b010}) begin
						decoded.opb_sel = OPB_S_IMM;
						decoded.wr_mem = 1'b1;
					end else begin
						decoded.illegal = 1'b1;
					end
				end
				OPC_IMM: begin
					// shift immediates keep funct7 in the upper bits
					if ((inst.funct3 == F3_SLL && inst.funct7 != F7_BASE) ||
							(inst.funct3 == F3_SR && !(inst.funct7 inside {F7_BASE, F7_ALT}))) begin
						decoded.illegal = 1'b1;
					end else begin
						decoded.opb_sel = OPB_I_IMM;
						decoded.alu_func = int_func(inst.funct3,
							(inst.funct3 == F3_SR) && (inst.funct7 == F7_ALT));
						writes_rd = 1'b1;
					end
				end
				OPC_REG: begin
					if (inst.funct7 == F7_MULDIV) begin
						decoded.unit = MULT;
						// only the multiply half of M is supported
						case (inst.funct3)
							3'b000: decoded.alu_func = ALU_MUL;
							3'b001: decoded.alu_func = ALU_MULH;
							3'b010: decoded.alu_func = ALU_MULHSU;
							3'b011: decoded.alu_func = ALU_MULHU;
							default: decoded.illegal = 1'b1;
						endcase
						writes_rd = !decoded.illegal;
					end else if (inst.funct7 == F7_BASE) begin
						decoded.alu_func = int_func(inst.funct3, 1'b0);
						writes_rd = 1'b1;
					end else if (inst.funct7 == F7_ALT &&
							(inst.funct3 == F3_ADD || inst.funct3 == F3_SR)) begin
						decoded.alu_func = int_func(inst.funct3, 1'b1);
						writes_rd = 1'b1;
					end else begin
						decoded.illegal = 1'b1;
					end
				end
				default: decoded.illegal = 1'b1;
			endcase
		end
		decoded.dest_idx = writes_rd ? lane.dest_tag : `TAG_BITS'(`ZERO_REG);
	end

endmodule

/* hw/issue_select.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_select (
	input  logic clock,
	input  logic reset,
	input  issue_pkg::rs_lane_t [`N_WAY-1:0] lanes,
	input  issue_pkg::decoded_t [`N_WAY-1:0] decoded,
	input  logic [`N_WAY-1:0][`XLEN-1:0] rs1_values,
	input  logic [`N_WAY-1:0][`XLEN-1:0] rs2_values,
	output issue_pkg::issue_packet_t [`N_WAY-1:0] issue_packets,
	output logic [$clog2(`N_WAY+1)-1:0] free_slots
);
	import issue_pkg::*;

	localparam int CNT_W = $clog2(`N_WAY + 1);
	localparam int N_UNITS = 5;

	// rank 1 is the oldest held instruction
	typedef struct packed {
		logic busy;
		logic [CNT_W-1:0] rank;
		issue_packet_t pkt;
	} hold_entry_t;

	hold_entry_t [`N_WAY-1:0] entries;
	hold_entry_t [`N_WAY-1:0] next_entries;
	logic [CNT_W-1:0] n_busy;
	logic [CNT_W-1:0] n_lanes_valid;

	function automatic int unit_limit(input exec_unit_e u);
		case (u)
			MULT: return `EX_MULT_UNITS;
			LOAD: return `EX_LOAD_UNITS;
			STORE: return `EX_STORE_UNITS;
			BRANCH: return `EX_BRANCH_UNITS;
			default: return `EX_ALU_UNITS;
		endcase
	endfunction

	function automatic issue_packet_t make_packet(input rs_lane_t lane, input decoded_t dec,
			input logic [`XLEN-1:0] rs1, input logic [`XLEN-1:0] rs2);
		issue_packet_t p;
		p.valid = 1'b1;
		p.pc = lane.pc;
		p.npc = lane.npc;
		p.inst = lane.inst;
		p.rs1_value = rs1;
		p.rs2_value = rs2;
		p.opa_sel = dec.opa_sel;
		p.opb_sel = dec.opb_sel;
		p.alu_func = dec.alu_func;
		p.rd_mem = dec.rd_mem;
		p.wr_mem = dec.wr_mem;
		p.cond_branch = dec.cond_branch;
		p.uncond_branch = dec.uncond_branch;
		p.illegal = dec.illegal;
		p.unit = dec.unit;
		p.dest_idx = dec.dest_idx;
		return p;
	endfunction

	always_comb begin
		n_busy = '0;
		n_lanes_valid = '0;
		for (int k = 0; k < `N_WAY; k++) begin
			n_busy = n_busy + CNT_W'(entries[k].busy);
			n_lanes_valid = n_lanes_valid + CNT_W'(lanes[k].valid);
		end
	end

	assign free_slots = CNT_W'(`N_WAY) - n_busy;

	//////////////////////////////////////////////////
	// selection with held entries first
	//////////////////////////////////////////////////

	always_comb begin : pick
		int n_issued;
		int n_kept;
		logic placed;
		int budget [N_UNITS];
		issue_packet_t cand;
		issue_packets = '0;
		next_entries = entries;
		n_issued = 0;
		for (int u = 0; u < N_UNITS; u++) begin
			budget[u] = unit_limit(exec_unit_e'(u));
		end
		// a blocked entry does not stop younger ones
		for (int r = 1; r <= `N_WAY; r++) begin
			for (int e = 0; e < `N_WAY; e++) begin
				if (entries[e].busy && entries[e].rank == CNT_W'(r) &&
						budget[entries[e].pkt.unit] > 0 && n_issued < `N_WAY) begin
					issue_packets[n_issued] = entries[e].pkt;
					budget[entries[e].pkt.unit]--;
					n_issued++;
					next_entries[e].busy = 1'b0;
				end
			end
		end
		// close up the ranks of what stays
		n_kept = 0;
		for (int r = 1; r <= `N_WAY; r++) begin
			for (int e = 0; e < `N_WAY; e++) begin
				if (next_entries[e].busy && entries[e].rank == CNT_W'(r)) begin
					n_kept++;
					next_entries[e].rank = CNT_W'(n_kept);
				end
			end
		end
		// leftover new lanes queue behind the held ones
		for (int l = 0; l < `N_WAY; l++) begin
			cand = make_packet(lanes[l], decoded[l], rs1_values[l], rs2_values[l]);
			placed = 1'b0;
			if (lanes[l].valid) begin
				if (budget[decoded[l].unit] > 0 && n_issued < `N_WAY) begin
					issue_packets[n_issued] = cand;
					budget[decoded[l].unit]--;
					n_issued++;
				end else begin
					for (int e = 0; e < `N_WAY; e++) begin
						if (!placed && !next_entries[e].busy) begin
							n_kept++;
							next_entries[e].busy = 1'b1;
							next_entries[e].rank = CNT_W'(n_kept);
							next_entries[e].pkt = cand;
							placed = 1'b1;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			entries <= '0;
		end else begin
			entries <= next_entries;
		end
	end

	// upstream must stay within the advertised credit
	lane_credit_a: assert property (@(posedge clock) disable iff (reset)
		n_lanes_valid <= free_slots);

	// held ranks stay packed between 1 and the number of busy entries
	for (genvar e = 0; e < `N_WAY; e++) begin : g_rank_chk
		rank_range_a: assert property (@(posedge clock) disable iff (reset)
			entries[e].busy |-> (entries[e].rank != '0 && entries[e].rank <= n_busy));
	end

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_stage (
	input  logic clock,
	input  logic reset,
	input  issue_pkg::rs_lane_t [`N_WAY-1:0] lanes,
	input  issue_pkg::wb_port_t [`N_WAY-1:0] wb,
	output issue_pkg::issue_packet_t [`N_WAY-1:0] issue_packets,
	output logic [$clog2(`N_WAY+1)-1:0] free_slots
);
	import issue_pkg::*;

	logic [`N_WAY-1:0][`TAG_BITS-1:0] rd_tags_1;
	logic [`N_WAY-1:0][`TAG_BITS-1:0] rd_tags_2;
	logic [`N_WAY-1:0][`XLEN-1:0] rs1_values;
	logic [`N_WAY-1:0][`XLEN-1:0] rs2_values;
	decoded_t [`N_WAY-1:0] decoded;

	issue_regfile i_regfile (
		.clock(clock),
		.wb(wb),
		.rd_tags_1(rd_tags_1),
		.rd_tags_2(rd_tags_2),
		.rs1_values(rs1_values),
		.rs2_values(rs2_values)
	);

	// one decoder per lane
	for (genvar k = 0; k < `N_WAY; k++) begin : g_lane
		assign rd_tags_1[k] = lanes[k].src_tag_1;
		assign rd_tags_2[k] = lanes[k].src_tag_2;

		inst_decoder i_decoder (
			.lane(lanes[k]),
			.decoded(decoded[k])
		);
	end

	issue_select i_select (
		.clock(clock),
		.reset(reset),
		.lanes(lanes),
		.decoded(decoded),
		.rs1_values(rs1_values),
		.rs2_values(rs2_values),
		.issue_packets(issue_packets),
		.free_slots(free_slots)
	);

endmodule

/* bench/issue_checker.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_checker (
	input  logic clock,
	input  logic check_en,
	input  logic done,
	input  int test_id,
	input  issue_pkg::issue_packet_t [`N_WAY-1:0] issue_packets,
	input  logic [$clog2(`N_WAY+1)-1:0] free_slots,
	input  int exp_count,
	input  logic [`N_WAY-1:0][`TAG_BITS-1:0] exp_dest,
	input  logic [`N_WAY-1:0][15:0] exp_ctl,
	input  logic [`N_WAY-1:0][`XLEN-1:0] exp_rs1,
	input  logic [$clog2(`N_WAY+1)-1:0] exp_free,
	output logic finished,
	output int n_tests,
	output int n_bad_tests,
	output int n_errors
);
	import issue_pkg::*;

	int cur_test = 0;
	int test_checks = 0;
	int test_errors = 0;
	int total_tests = 0;
	int bad_tests = 0;
	int total_errors = 0;
	logic end_seen = 1'b0;

	assign finished = end_seen;
	assign n_tests = total_tests;
	assign n_bad_tests = bad_tests;
	assign n_errors = total_errors;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		test_checks++;
		if (expected !== actual) begin
			$display("Fail %s in test %0d: expected %h, got %h", name, cur_test,
				expected, actual);
			test_errors++;
		end
	endtask

	task automatic close_test();
		$display("test %0d finished: %0d checks, %0d errors", cur_test, test_checks,
			test_errors);
		total_tests++;
		total_errors += test_errors;
		if (test_errors != 0) begin
			bad_tests++;
		end
	endtask

	// ctl nibbles from the top: illegal, opa_sel, opb_sel, unit
	task automatic compare_cycle();
		issue_packet_t pkt;
		check_value("free_slots", 32'(exp_free), 32'(free_slots));
		for (int s = 0; s < `N_WAY; s++) begin
			pkt = issue_packets[s];
			if (s < exp_count) begin
				check_value($sformatf("issue_packets[%0d].valid", s), 32'd1, 32'(pkt.valid));
				check_value($sformatf("issue_packets[%0d].dest_idx", s), 32'(exp_dest[s]),
					32'(pkt.dest_idx));
				check_value($sformatf("issue_packets[%0d].illegal", s),
					32'(exp_ctl[s][15:12]), 32'(pkt.illegal));
				check_value($sformatf("issue_packets[%0d].opa_sel", s),
					32'(exp_ctl[s][11:8]), 32'(pkt.opa_sel));
				check_value($sformatf("issue_packets[%0d].opb_sel", s),
					32'(exp_ctl[s][7:4]), 32'(pkt.opb_sel));
				check_value($sformatf("issue_packets[%0d].unit", s),
					32'(exp_ctl[s][3:0]), 32'(pkt.unit));
				check_value($sformatf("issue_packets[%0d].rs1_value", s), exp_rs1[s],
					pkt.rs1_value);
			end else begin
				test_checks++;
				if (pkt !== '0) begin
					$display("slot %0d of issue_packets holds data above the issue count in test %0d",
						s, cur_test);
					test_errors++;
				end
			end
		end
	endtask

	// sample 1 ns ahead of the rising edge
	always @(negedge clock) begin
		#1;
		if (check_en) begin
			if (test_id != cur_test) begin
				if (cur_test != 0) begin
					close_test();
				end
				cur_test = test_id;
				test_checks = 0;
				test_errors = 0;
			end
			compare_cycle();
		end else if (done && !end_seen) begin
			if (cur_test != 0) begin
				close_test();
			end
			end_seen = 1'b1;
		end
	end

endmodule

/* bench/tb_issue_stage.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module tb_issue_stage;
	import rv32_isa_pkg::*;
	import issue_pkg::*;

	localparam int MAX_LINES = 200;
	localparam int WAIT_LIMIT = 20;
	localparam logic [$clog2(`N_WAY+1)-1:0] ALL_FREE = `N_WAY;

	logic clock = 1'b0;
	logic reset;
	rs_lane_t [`N_WAY-1:0] lanes;
	wb_port_t [`N_WAY-1:0] wb;
	issue_packet_t [`N_WAY-1:0] issue_packets;
	logic [$clog2(`N_WAY+1)-1:0] free_slots;

	// per-cycle expectations handed to the checker
	logic check_en;
	logic done;
	int test_id;
	int exp_count;
	logic [`N_WAY-1:0][`TAG_BITS-1:0] exp_dest;
	logic [`N_WAY-1:0][15:0] exp_ctl;
	logic [`N_WAY-1:0][`XLEN-1:0] exp_rs1;
	logic [$clog2(`N_WAY+1)-1:0] exp_free;

	logic finished;
	int n_tests;
	int n_bad_tests;
	int n_errors;
	int tb_errors = 0;
	logic timed_out = 1'b0;

	// fields of one data line
	int f_test;
	int f_count;
	logic [31:0] f_inst [`N_WAY];
	logic [`TAG_BITS-1:0] f_src1 [`N_WAY];
	logic [`TAG_BITS-1:0] f_src2 [`N_WAY];
	logic [`TAG_BITS-1:0] f_dst [`N_WAY];
	logic [`TAG_BITS-1:0] f_exp_dest [`N_WAY];
	logic [15:0] f_ctl [`N_WAY];
	logic [`XLEN-1:0] f_rs1 [`N_WAY];
	logic f_wb_en;
	logic [`TAG_BITS-1:0] f_wb_idx;
	logic [`XLEN-1:0] f_wb_data;
	logic [$clog2(`N_WAY+1)-1:0] f_free;

	always #2 clock = ~clock;

	issue_stage i_dut (
		.clock(clock),
		.reset(reset),
		.lanes(lanes),
		.wb(wb),
		.issue_packets(issue_packets),
		.free_slots(free_slots)
	);

	issue_checker i_checker (
		.clock(clock),
		.check_en(check_en),
		.done(done),
		.test_id(test_id),
		.issue_packets(issue_packets),
		.free_slots(free_slots),
		.exp_count(exp_count),
		.exp_dest(exp_dest),
		.exp_ctl(exp_ctl),
		.exp_rs1(exp_rs1),
		.exp_free(exp_free),
		.finished(finished),
		.n_tests(n_tests),
		.n_bad_tests(n_bad_tests),
		.n_errors(n_errors)
	);

	// only write port 0 comes from the file
	task automatic apply_line(input int line_no);
		for (int k = 0; k < `N_WAY; k++) begin
			lanes[k].valid = (f_inst[k] != 32'd0);
			lanes[k].inst = inst_word_t'(f_inst[k]);
			lanes[k].pc = 32'h1000 + 32'(line_no * 16 + k * 4);
			lanes[k].npc = lanes[k].pc + 32'd4;
			lanes[k].src_tag_1 = f_src1[k];
			lanes[k].src_tag_2 = f_src2[k];
			lanes[k].dest_tag = f_dst[k];
			exp_dest[k] = f_exp_dest[k];
			exp_ctl[k] = f_ctl[k];
			exp_rs1[k] = f_rs1[k];
		end
		wb = '0;
		wb[0].en = f_wb_en;
		wb[0].idx = f_wb_idx;
		wb[0].data = f_wb_data;
		test_id = f_test;
		exp_count = f_count;
		exp_free = f_free;
		check_en = 1'b1;
	endtask

	task automatic run_file();
		int fd;
		int n;
		int n_lines;
		int n_data;
		string line;
		fd = $fopen("bench/issue_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/issue_testdata.txt");
			tb_errors++;
			return;
		end
		n_lines = 0;
		n_data = 0;
		while (!$feof(fd) && n_lines < MAX_LINES) begin
			n_lines++;
			if ($fgets(line, fd) != 0 && line.len() > 3 && line.getc(0) != "#") begin
				n = $sscanf(line,
					"%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h %h %h %h %h %h",
					f_test,
					f_inst[0], f_src1[0], f_src2[0], f_dst[0],
					f_inst[1], f_src1[1], f_src2[1], f_dst[1],
					f_inst[2], f_src1[2], f_src2[2], f_dst[2],
					f_wb_en, f_wb_idx, f_wb_data,
					f_count,
					f_exp_dest[0], f_ctl[0], f_rs1[0],
					f_exp_dest[1], f_ctl[1], f_rs1[1],
					f_exp_dest[2], f_ctl[2], f_rs1[2],
					f_free);
				if (n == 27) begin
					apply_line(n_data);
					n_data++;
					@(negedge clock);
				end else begin
					$display("malformed data line %0d: %s", n_lines, line);
					tb_errors++;
				end
			end
		end
		if (n_lines >= MAX_LINES) begin
			$display("data file did not end within %0d lines", MAX_LINES);
			timed_out = 1'b1;
		end
		$fclose(fd);
	endtask

	initial begin : main
		int n;
		reset = 1'b1;
		lanes = '0;
		wb = '0;
		check_en = 1'b0;
		done = 1'b0;
		test_id = 0;
		exp_count = 0;
		exp_dest = '0;
		exp_ctl = '0;
		exp_rs1 = '0;
		exp_free = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		n = 0;
		while (free_slots != ALL_FREE && n < WAIT_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (free_slots != ALL_FREE) begin
			$display("free_slots never settled after reset");
			timed_out = 1'b1;
		end else begin
			run_file();
		end
		// idle lanes while the checker closes the last test
		lanes = '0;
		wb = '0;
		check_en = 1'b0;
		done = 1'b1;
		n = 0;
		while (!finished && n < WAIT_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (!finished) begin
			$display("checker did not close the last test in time");
			timed_out = 1'b1;
		end
		$display("%0d tests run, %0d failed, %0d errors", n_tests, n_bad_tests,
			n_errors + tb_errors);
		if (!timed_out && tb_errors == 0 && n_errors == 0 && n_tests > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* bench/issue_testdata.txt */
# test | lanes 0..2: inst src1 src2 dest (inst 0 = idle) | wb0: en idx data | issue count
# slots 0..2: dest ctl rs1 (ctl nibbles: illegal opa_sel opb_sel unit) | free_slots
1 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 0 00 0000 0 00 0000 0 00 0000 0 3
2 0 00 00 00 0 00 00 00 0 00 00 00 1 05 1111 0 00 0000 0 00 0000 0 00 0000 0 3
2 002081b3 05 00 0a 0 00 00 00 0 00 00 00 1 05 2222 1 0a 0000 1111 00 0000 0 00 0000 0 3
2 002081b3 05 00 0b 01008293 00 00 0c 0 00 00 00 1 00 dead 2 0b 0000 2222 0c 0010 0 00 0000 0 3
2 002081b3 00 00 0d 0 00 00 00 0 00 00 00 0 00 0 1 0d 0000 0 00 0000 0 00 0000 0 3
3 0080a303 05 00 10 0020a223 05 00 11 00208463 05 00 12 0 00 0 3 10 0012 2222 00 0023 2222 00 0134 2222 3
3 010000ef 00 00 13 022083b3 05 00 14 0000007f 00 00 15 0 00 0 3 13 0150 0 14 0001 2222 00 1000 0 3
4 0080a303 00 00 20 0080a303 00 00 21 0080a303 00 00 22 0 00 0 1 20 0012 0 00 0000 0 00 0000 0 3
4 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 1 21 0012 0 00 0000 0 00 0000 0 1
4 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 1 22 0012 0 00 0000 0 00 0000 0 2
4 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 0 00 0000 0 00 0000 0 00 0000 0 3
5 022083b3 00 00 30 022083b3 00 00 31 022083b3 00 00 32 0 00 0 1 30 0001 0 00 0000 0 00 0000 0 3
5 002081b3 05 00 33 0 00 00 00 0 00 00 00 0 00 0 2 31 0001 0 33 0000 2222 00 0000 0 1
5 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 1 32 0001 0 00 0000 0 00 0000 0 2
6 0080a303 00 00 40 0080a303 00 00 41 0080a303 00 00 42 0 00 0 1 40 0012 0 00 0000 0 00 0000 0 3
6 0080a303 00 00 43 0 00 00 00 0 00 00 00 0 00 0 1 41 0012 0 00 0000 0 00 0000 0 1
6 0080a303 00 00 44 0 00 00 00 0 00 00 00 0 00 0 1 42 0012 0 00 0000 0 00 0000 0 1
6 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 1 43 0012 0 00 0000 0 00 0000 0 1
6 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 1 44 0012 0 00 0000 0 00 0000 0 2
6 0 00 00 00 0 00 00 00 0 00 00 00 0 00 0 0 00 0000 0 00 0000 0 00 0000 0 3

/* flist.f */
+incdir+include
hw/rv32_isa_pkg.sv
hw/issue_pkg.sv
hw/issue_regfile.sv
hw/inst_decoder.sv
hw/issue_select.sv
hw/issue_stage.sv
bench/issue_checker.sv
bench/tb_issue_stage.sv

/* Makefile */
TOP := tb_issue_stage
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) \
		-Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
